/* Makefile */
VERILATOR ?= verilator
SIMFLAGS  = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_branch_predictor
FILELIST  = src.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@echo "simulation ok"

clean:
	rm -rf $(BUILD) $(LOG)

/* hw/bp_consts.svh */
/* sizes of the predictor tables and statistics counters
   index and tag ranges assume a 32-bit pc with word-aligned instructions */
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

`define BP_ENTRIES 256  // depth of both tables
`define BP_IDX_LO  2    // lowest pc bit of the table index
`define BP_IDX_HI  9    // highest pc bit of the table index
`define BP_TAG_LO  10   // tag covers pc[31:BP_TAG_LO]

`define BP_DIR_W   2    // bits per direction counter
`define BP_CNT_W   10   // statistics counters, wrap on overflow

`endif

/* hw/bp_pkg.sv */
/* types shared by the branch predictor blocks
   widths follow the index and tag ranges in the constants header */
`default_nettype none

`include "bp_consts.svh"

package bp_pkg;

  typedef logic [`BP_IDX_HI-`BP_IDX_LO:0] bp_idx_t;  // 8-bit table index
  typedef logic [31:`BP_TAG_LO]           bp_tag_t;  // pc[31:10]

  typedef struct packed {
    bp_tag_t     tag;     // upper pc bits of the branch
    logic [31:0] target;  // last taken target
  } btb_entry_t;

  // upper two states predict taken
  typedef enum logic [`BP_DIR_W-1:0] {
    DIR_SNT = 2'd0,  // strongly not taken
    DIR_WNT = 2'd1,  // weakly not taken, also the value of an empty entry
    DIR_WT  = 2'd2,  // weakly taken
    DIR_ST  = 2'd3   // strongly taken
  } dir_cnt_t;

  typedef struct packed {
    logic        hit;     // valid entry with matching tag
    logic [31:0] target;
  } btb_lookup_t;

endpackage

`default_nettype wire

/* hw/bp_table.sv */
/* direct-mapped table, two async read ports and one write port
   reset clears only the valid bits, payload keeps whatever it held */
`timescale 1ns/1ps
`default_nettype none

`include "bp_consts.svh"

module bp_table import bp_pkg::*; #(
  parameter type entry_t = logic
) (
  input  wire logic    clk,
  input  wire logic    rst_i,
  input  wire bp_idx_t rd_idx,     // fetch-side lookup
  output logic         rd_valid,
  output entry_t       rd_data,
  input  wire bp_idx_t upd_idx,    // update-side lookup, for read-modify-write
  output logic         upd_valid,
  output entry_t       upd_data,
  input  wire logic    wr_en,
  input  wire bp_idx_t wr_idx,
  input  wire entry_t  wr_data
);

  entry_t                 mem [`BP_ENTRIES];
  logic [`BP_ENTRIES-1:0] valid_q;  // one bit per entry

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;  // any write makes the entry live
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // reads see the old contents during a write cycle
  assign rd_valid  = valid_q[rd_idx];
  assign rd_data   = mem[rd_idx];
  assign upd_valid = valid_q[upd_idx];
  assign upd_data  = mem[upd_idx];

endmodule

`default_nettype wire

/* hw/bp_update_if.sv */
/* resolution report from the memory stage, one per cycle at most
   valid is a single-cycle strobe, there is no handshake */
`timescale 1ns/1ps
`default_nettype none

interface bp_update_if;

  logic        valid;       // resolved branch this cycle
  logic [31:0] pc;          // pc of the branch
  logic [31:0] target;      // resolved target
  logic        taken;       // branch was taken
  logic        mispredict;  // fetch went the wrong way

  modport src (
    output valid, pc, target, taken, mispredict
  );

  modport sink (
    input valid, pc, target, taken, mispredict
  );

endinterface

`default_nettype wire

/* hw/branch_predictor.sv */
/* fetch-side branch predictor, combinational lookup from fetch_pc
   one resolution report per cycle, trained at the following edge */
`timescale 1ns/1ps
`default_nettype none

`include "bp_consts.svh"

module branch_predictor import bp_pkg::*; (
  input  wire logic         clk,
  input  wire logic         rst_i,
  input  wire logic         fetch_valid,
  input  wire logic [31:0]  fetch_pc,
  input  wire logic         upd_valid,
  input  wire logic [31:0]  upd_pc,
  input  wire logic [31:0]  upd_target,
  input  wire logic         upd_taken,
  input  wire logic         upd_mispredict,
  output logic [31:0]       next_pc,
  output logic              pred_taken,
  output logic              redirect,
  output logic [`BP_CNT_W-1:0] branch_cnt,
  output logic [`BP_CNT_W-1:0] hit_cnt
);

  bp_update_if upd_bus ();

  btb_lookup_t btb_lookup;     // hit and target for the fetch pc
  logic        dir_taken;      // counter says taken

  // memory-stage report onto the shared bundle
  assign upd_bus.valid      = upd_valid;
  assign upd_bus.pc         = upd_pc;
  assign upd_bus.target     = upd_target;
  assign upd_bus.taken      = upd_taken;
  assign upd_bus.mispredict = upd_mispredict;

  btb_store u_btb (
    .clk      (clk),
    .rst_i    (rst_i),
    .fetch_pc (fetch_pc),
    .upd      (upd_bus.sink),
    .lookup   (btb_lookup)
  );

  dir_predictor u_dir (
    .clk           (clk),
    .rst_i         (rst_i),
    .fetch_pc      (fetch_pc),
    .upd           (upd_bus.sink),
    .predict_taken (dir_taken)
  );

  next_pc_sel u_sel (
    .clk           (clk),
    .rst_i         (rst_i),
    .fetch_valid   (fetch_valid),
    .fetch_pc      (fetch_pc),
    .lookup        (btb_lookup),
    .predict_taken (dir_taken),
    .upd           (upd_bus.sink),
    .next_pc       (next_pc),
    .pred_taken    (pred_taken),
    .redirect      (redirect),
    .branch_cnt    (branch_cnt),
    .hit_cnt       (hit_cnt)
  );

endmodule

`default_nettype wire

/* hw/btb_store.sv */
/* branch target buffer, written only by taken branches
   aliasing pcs evict each other, the last taken one wins the entry */
`timescale 1ns/1ps
`default_nettype none

`include "bp_consts.svh"

module btb_store import bp_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst_i,
  input  wire logic [31:0] fetch_pc,
  bp_update_if.sink  upd,
  output btb_lookup_t lookup
);

  bp_idx_t    fetch_idx;
  bp_tag_t    fetch_tag;
  bp_idx_t    upd_idx;
  bp_tag_t    upd_tag;
  logic       rd_valid;
  btb_entry_t rd_entry;
  logic       wr_en;
  btb_entry_t wr_entry;

  assign fetch_idx = fetch_pc[`BP_IDX_HI:`BP_IDX_LO];
  assign fetch_tag = fetch_pc[31:`BP_TAG_LO];
  assign upd_idx   = upd.pc[`BP_IDX_HI:`BP_IDX_LO];
  assign upd_tag   = upd.pc[31:`BP_TAG_LO];

  assign wr_entry.tag    = upd_tag;
  assign wr_entry.target = upd.target;

  assign wr_en = upd.valid && upd.taken;  // only taken branches allocate

  bp_table #(
    .entry_t (btb_entry_t)
  ) u_table (
    .clk       (clk),
    .rst_i     (rst_i),
    .rd_idx    (fetch_idx),
    .rd_valid  (rd_valid),
    .rd_data   (rd_entry),
    .upd_idx   (upd_idx),
    .upd_valid (),
    .upd_data  (),
    .wr_en     (wr_en),
    .wr_idx    (upd_idx),
    .wr_data   (wr_entry)
  );

  assign lookup.hit    = rd_valid && (rd_entry.tag == fetch_tag);  // full tag compare
  assign lookup.target = rd_entry.target;

endmodule

`default_nettype wire

/* hw/dir_predictor.sv */
/* two-bit saturating counters indexed by pc[9:2], no tags
   every resolved branch trains its counter, aliases share one counter */
`timescale 1ns/1ps
`default_nettype none

`include "bp_consts.svh"

module dir_predictor import bp_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst_i,
  input  wire logic [31:0] fetch_pc,
  bp_update_if.sink  upd,
  output logic       predict_taken
);

  bp_idx_t  fetch_idx;
  bp_idx_t  upd_idx;
  logic     rd_valid;
  dir_cnt_t rd_cnt;
  logic     upd_valid;
  dir_cnt_t upd_cnt;
  dir_cnt_t fetch_state;  // counter seen by the lookup
  dir_cnt_t upd_state;    // counter before training
  dir_cnt_t next_state;   // counter after training

  assign fetch_idx = fetch_pc[`BP_IDX_HI:`BP_IDX_LO];
  assign upd_idx   = upd.pc[`BP_IDX_HI:`BP_IDX_LO];

  bp_table #(
    .entry_t (dir_cnt_t)
  ) u_table (
    .clk       (clk),
    .rst_i     (rst_i),
    .rd_idx    (fetch_idx),
    .rd_valid  (rd_valid),
    .rd_data   (rd_cnt),
    .upd_idx   (upd_idx),
    .upd_valid (upd_valid),
    .upd_data  (upd_cnt),
    .wr_en     (upd.valid),  // train on every resolved branch
    .wr_idx    (upd_idx),
    .wr_data   (next_state)
  );

  // empty entries behave as weakly not taken
  assign fetch_state = rd_valid ? rd_cnt : DIR_WNT;
  assign upd_state   = upd_valid ? upd_cnt : DIR_WNT;

  assign predict_taken = (fetch_state == DIR_WT) || (fetch_state == DIR_ST);

  // one step toward the outcome, held at either end
  always_comb begin
    case (upd_state)
      DIR_SNT: next_state = upd.taken ? DIR_WNT : DIR_SNT;
      DIR_WNT: next_state = upd.taken ? DIR_WT  : DIR_SNT;
      DIR_WT:  next_state = upd.taken ? DIR_ST  : DIR_WNT;
      DIR_ST:  next_state = upd.taken ? DIR_ST  : DIR_WT;
      default: next_state = DIR_WNT;
    endcase
  end

endmodule

`default_nettype wire

/* hw/next_pc_sel.sv */
/* next fetch address: redirect first, then taken prediction, then pc+4
   outputs are combinational, fetch ignores them while fetch_valid is low */
`timescale 1ns/1ps
`default_nettype none

`include "bp_consts.svh"

module next_pc_sel import bp_pkg::*; (
  input  wire logic         clk,
  input  wire logic         rst_i,
  input  wire logic         fetch_valid,
  input  wire logic [31:0]  fetch_pc,
  input  wire btb_lookup_t  lookup,
  input  wire logic         predict_taken,
  bp_update_if.sink         upd,
  output logic [31:0]       next_pc,
  output logic              pred_taken,
  output logic              redirect,
  output logic [`BP_CNT_W-1:0] branch_cnt,
  output logic [`BP_CNT_W-1:0] hit_cnt
);

  always_comb begin
    next_pc    = fetch_pc + 32'd4;  // sequential by default
    pred_taken = 1'b0;
    redirect   = 1'b0;
    if (upd.valid && upd.mispredict) begin
      redirect = 1'b1;  // memory stage overrides the fetch lookup
      next_pc  = upd.taken ? upd.target : upd.pc + 32'd4;
    end else if (fetch_valid && lookup.hit && predict_taken) begin
      pred_taken = 1'b1;
      next_pc    = lookup.target;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      branch_cnt <= '0;
    end else if (upd.valid) begin
      branch_cnt <= branch_cnt + 1'b1;  // wraps
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      hit_cnt <= '0;
    end else if (pred_taken) begin
      hit_cnt <= hit_cnt + 1'b1;  // wraps
    end
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/bp_pkg.sv
hw/bp_update_if.sv
hw/bp_table.sv
hw/btb_store.sv
hw/dir_predictor.sv
hw/next_pc_sel.sv
hw/branch_predictor.sv
test/tb_branch_predictor.sv

/* test/tb_branch_predictor.sv */
/* directed tests against a table model of the predictor, inputs change on the rising edge
   and every check runs at the falling edge, when the combinational outputs have settled */
`timescale 1ns/1ps
`default_nettype none

`include "bp_consts.svh"

module tb_branch_predictor;

  localparam int MAX_CYCLES = 700;  // tests take about 345 cycles

  logic        clk, rst_i, fetch_valid, upd_valid, upd_taken, upd_mispredict;
  logic [31:0] fetch_pc, upd_pc, upd_target, next_pc;
  logic        pred_taken, redirect;
  logic [`BP_CNT_W-1:0] branch_cnt, hit_cnt;

  logic                 m_bvalid [`BP_ENTRIES];  // model of the target buffer
  logic [31:`BP_TAG_LO] m_tag    [`BP_ENTRIES];
  logic [31:0]          m_target [`BP_ENTRIES];
  logic [1:0]           m_cnt    [`BP_ENTRIES];  // 0 strongly not taken .. 3 strongly taken
  logic [`BP_CNT_W-1:0] m_branches, m_hits;     // wrap like the DUT counters
  logic [31:0]          rng;
  int                   errors, checks, tests, cycles;

  branch_predictor uut (
    .clk(clk), .rst_i(rst_i), .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
    .upd_valid(upd_valid), .upd_pc(upd_pc), .upd_target(upd_target),
    .upd_taken(upd_taken), .upd_mispredict(upd_mispredict), .next_pc(next_pc),
    .pred_taken(pred_taken), .redirect(redirect), .branch_cnt(branch_cnt), .hit_cnt(hit_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  // four indices with two tags each, so entries alias
  function automatic logic [31:0] pick_pc(input logic [2:0] sel);
    return 32'h0000_1000 + {28'h0, sel[1:0], 2'b00} + (sel[2] ? 32'h400 : 32'h0);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // one cycle: drive, check against the model's old state, then train the model
  task automatic step(input logic fv, input logic [31:0] fpc, input logic uv,
                      input logic [31:0] upc, input logic [31:0] utgt, input logic ut,
                      input logic um);
    int          fi;
    int          ui;
    logic        exp_redirect;
    logic        exp_pred;
    logic [31:0] exp_next;
    @(posedge clk);
    fetch_valid <= fv;
    fetch_pc    <= fpc;
    upd_valid   <= uv;
    upd_pc      <= upc;
    upd_target  <= utgt;
    upd_taken   <= ut;
    upd_mispredict <= um;
    @(negedge clk);
    fi = fpc[`BP_IDX_HI:`BP_IDX_LO];
    ui = upc[`BP_IDX_HI:`BP_IDX_LO];
    exp_redirect = uv && um;
    exp_pred = !exp_redirect && fv && m_bvalid[fi] && (m_tag[fi] == fpc[31:`BP_TAG_LO])
               && m_cnt[fi][1];  // upper two counter states
    exp_next = exp_redirect ? (ut ? utgt : upc + 32'd4) : exp_pred ? m_target[fi] : fpc + 32'd4;
    check_val("next_pc", next_pc, exp_next);
    check_val("pred_taken", pred_taken, exp_pred);
    check_val("redirect", redirect, exp_redirect);
    check_val("branch_cnt", branch_cnt, m_branches);
    check_val("hit_cnt", hit_cnt, m_hits);
    if (exp_pred) m_hits++;
    if (uv) begin
      m_branches++;
      if (ut && m_cnt[ui] != 2'd3) m_cnt[ui]++;  // saturate at both ends
      if (!ut && m_cnt[ui] != 2'd0) m_cnt[ui]--;
      if (ut) begin
        m_bvalid[ui] = 1'b1;
        m_tag[ui]    = upc[31:`BP_TAG_LO];
        m_target[ui] = utgt;
      end
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("%-12s finished, %0d errors", name, errors - err_before);
  endtask

  task automatic after_reset_test();
    int e0;
    e0 = errors;
    repeat (16) begin
      rng = xorshift32(rng);
      step(1'b1, {rng[31:2], 2'b00}, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);  // empty tables
    end
    report_test("after_reset", e0);
  endtask

  task automatic training_test();
    int e0;
    e0 = errors;
    step(1'b0, 32'h0, 1'b1, 32'h2040, 32'h3000, 1'b1, 1'b0);  // counter to weakly taken
    step(1'b1, 32'h2040, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    check_val("next_pc", next_pc, 32'h3000);
    step(1'b0, 32'h0, 1'b1, 32'h2040, 32'h0, 1'b0, 1'b0);
    step(1'b0, 32'h0, 1'b1, 32'h2040, 32'h0, 1'b0, 1'b0);     // down to strongly not taken
    step(1'b1, 32'h2040, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    check_val("next_pc", next_pc, 32'h2044);                  // btb hits, counter says no
    report_test("training", e0);
  endtask

  task automatic alias_test();
    int e0;
    e0 = errors;
    step(1'b0, 32'h0, 1'b1, 32'h6100, 32'h6800, 1'b1, 1'b0);
    step(1'b0, 32'h0, 1'b1, 32'h6100, 32'h6800, 1'b1, 1'b0);
    step(1'b1, 32'h6100, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    step(1'b1, 32'h6500, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);     // same index, other tag
    check_val("next_pc", next_pc, 32'h6504);
    report_test("alias", e0);
  endtask

  task automatic redirect_test();
    int e0;
    e0 = errors;
    step(1'b1, 32'h6100, 1'b1, 32'h7010, 32'h8000, 1'b1, 1'b1);  // beats a taken prediction
    check_val("next_pc", next_pc, 32'h8000);
    step(1'b1, 32'h6100, 1'b1, 32'h7010, 32'h8000, 1'b0, 1'b1);
    check_val("next_pc", next_pc, 32'h7014);
    step(1'b1, 32'h9020, 1'b1, 32'h9020, 32'ha000, 1'b1, 1'b0);  // training not visible yet
    step(1'b1, 32'h9020, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    report_test("redirect", e0);
  endtask

  task automatic random_mix_test();
    int          e0;
    logic [31:0] r;
    logic [31:0] t;
    e0 = errors;
    repeat (300) begin
      rng = xorshift32(rng);
      r   = rng;
      rng = xorshift32(rng);
      t   = rng;
      step(r[8], pick_pc(r[2:0]), r[9] | r[10], pick_pc(r[5:3]), {t[31:2], 2'b00},
           r[11], r[12] & r[13]);
    end
    report_test("random_mix", e0);
  endtask

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("test failed");
    $finish;
  end

  initial begin
    rst_i = 1'b1;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    upd_valid = 1'b0;
    upd_pc = '0;
    upd_target = '0;
    upd_taken = 1'b0;
    upd_mispredict = 1'b0;
    rng = 32'h86ef325b;
    errors = 0;
    checks = 0;
    tests = 0;
    m_branches = '0;
    m_hits = '0;
    for (int i = 0; i < `BP_ENTRIES; i++) begin
      m_bvalid[i] = 1'b0;
      m_cnt[i]    = 2'd1;  // empty entry reads as weakly not taken
    end
    repeat (10) @(posedge clk);
    rst_i <= 1'b0;
    after_reset_test();
    training_test();
    alias_test();
    redirect_test();
    random_mix_test();
    step(1'b0, 32'h0, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
